/* design/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// control stages between decode and retire, 1 or more
`define CORE_NUM_STAGES 3

`define CORE_REG_W  5   // register index
`define CORE_IMM_W  13  // scalar immediate
`define CORE_INSN_W 32

`endif

/* design/isa_pkg.sv */
`default_nettype none

`include "core_config.svh"

package isa_pkg;

        // c..f are unused and retire as nop
        typedef enum logic [3:0] {
                OP_ADD   = 4'h0,
                OP_SUB   = 4'h1,
                OP_AND   = 4'h2,
                OP_OR    = 4'h3,
                OP_LOAD  = 4'h4,
                OP_STORE = 4'h5,
                OP_JUMP  = 4'h6,
                OP_HALT  = 4'h7,
                OP_VADD  = 4'h8,
                OP_VSUB  = 4'h9,
                OP_VMUL  = 4'hA,
                OP_VAND  = 4'hB
        } opcode_e;

        typedef struct packed {
                opcode_e                opcode;
                logic [`CORE_REG_W-1:0] rd;
                logic [`CORE_REG_W-1:0] rs1;
                logic [`CORE_REG_W-1:0] rs2;
                logic [`CORE_IMM_W-1:0] imm;
        } scalar_fmt_t;

        typedef struct packed {
                opcode_e                                 opcode;
                logic [`CORE_REG_W-1:0]                  vd;
                logic [`CORE_REG_W-1:0]                  vs1;
                logic [`CORE_REG_W-1:0]                  vs2;
                logic                                    mask;
                logic [`CORE_INSN_W-4-3*`CORE_REG_W-2:0] rsvd;  // 12 bits by default
        } vector_fmt_t;

        // opcode sits in the top nibble of both views
        typedef union packed {
                scalar_fmt_t s;
                vector_fmt_t v;
        } insn_word_u;

endpackage

`default_nettype wire

/* design/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

        // low two bits follow the opcode, top bit marks a vector op
        typedef enum logic [3:0] {
                ALU_ADD  = 4'h0,
                ALU_SUB  = 4'h1,
                ALU_AND  = 4'h2,
                ALU_OR   = 4'h3,
                ALU_VADD = 4'h8,
                ALU_VSUB = 4'h9,
                ALU_VMUL = 4'hA,
                ALU_VAND = 4'hB
        } alu_op_e;

        typedef enum logic [2:0] {
                RET_ALU   = 3'd0,
                RET_VALU  = 3'd1,
                RET_LOAD  = 3'd2,
                RET_STORE = 3'd3,
                RET_JUMP  = 3'd4,
                RET_HALT  = 3'd5,
                RET_NOP   = 3'd6
        } retire_kind_e;

endpackage

`default_nettype wire

/* design/insn_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module insn_decoder
        import isa_pkg::*;
        import ctrl_pkg::*;
(
        input  logic [`CORE_INSN_W-1:0] insn,
        output logic                    ctrl_d_reg_wr_en,
        output logic                    ctrl_d_vec_wr_en,
        output logic                    ctrl_d_mem_read,
        output logic                    ctrl_d_mem_write,
        output logic                    ctrl_d_branch_jump,
        output logic                    ctrl_d_halt,
        output alu_op_e                 ctrl_d_alu_op,
        output logic [`CORE_REG_W-1:0]  ctrl_d_dst,
        output logic [`CORE_REG_W-1:0]  ctrl_d_src1,
        output logic [`CORE_REG_W-1:0]  ctrl_d_src2,
        output logic [`CORE_IMM_W-1:0]  ctrl_d_imm,
        output logic                    ctrl_d_mask
);

        insn_word_u word;

        assign word = insn;

        always_comb begin
                ctrl_d_reg_wr_en   = 1'b0;
                ctrl_d_vec_wr_en   = 1'b0;
                ctrl_d_mem_read    = 1'b0;
                ctrl_d_mem_write   = 1'b0;
                ctrl_d_branch_jump = 1'b0;
                ctrl_d_halt        = 1'b0;
                ctrl_d_alu_op      = ALU_ADD;      // address add for load/store
                // scalar view unless a vector opcode says otherwise
                ctrl_d_dst         = word.s.rd;
                ctrl_d_src1        = word.s.rs1;
                ctrl_d_src2        = word.s.rs2;
                ctrl_d_imm         = word.s.imm;
                ctrl_d_mask        = 1'b0;

                case (word.s.opcode)
                        OP_ADD, OP_SUB, OP_AND, OP_OR: begin
                                ctrl_d_reg_wr_en = 1'b1;
                                ctrl_d_alu_op    = alu_op_e'({2'b00, word.s.opcode[1:0]});
                        end
                        OP_LOAD: begin
                                ctrl_d_mem_read  = 1'b1;
                                ctrl_d_reg_wr_en = 1'b1;
                        end
                        OP_STORE: ctrl_d_mem_write   = 1'b1;
                        OP_JUMP:  ctrl_d_branch_jump = 1'b1;
                        OP_HALT:  ctrl_d_halt        = 1'b1;
                        OP_VADD, OP_VSUB, OP_VMUL, OP_VAND: begin
                                ctrl_d_vec_wr_en = 1'b1;
                                ctrl_d_alu_op    = alu_op_e'({2'b10, word.v.opcode[1:0]});
                                ctrl_d_dst       = word.v.vd;
                                ctrl_d_src1      = word.v.vs1;
                                ctrl_d_src2      = word.v.vs2;
                                ctrl_d_imm       = '0;     // no immediate in the vector view
                                ctrl_d_mask      = word.v.mask;
                        end
                        default: ;      // unused opcode, every enable stays low
                endcase
        end

endmodule

`default_nettype wire

/* design/control_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module control_stage
        import ctrl_pkg::*;
(
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   flush,
        input  logic                   in_valid,
        output logic                   in_ready,
        input  logic                   in_reg_wr_en,
        input  logic                   in_vec_wr_en,
        input  logic                   in_mem_read,
        input  logic                   in_mem_write,
        input  logic                   in_branch_jump,
        input  logic                   in_halt,
        input  alu_op_e                in_alu_op,
        input  logic [`CORE_REG_W-1:0] in_dst,
        input  logic [`CORE_REG_W-1:0] in_src1,
        input  logic [`CORE_REG_W-1:0] in_src2,
        input  logic [`CORE_IMM_W-1:0] in_imm,
        input  logic                   in_mask,
        output logic                   out_valid,
        input  logic                   out_ready,
        output logic                   out_reg_wr_en,
        output logic                   out_vec_wr_en,
        output logic                   out_mem_read,
        output logic                   out_mem_write,
        output logic                   out_branch_jump,
        output logic                   out_halt,
        output alu_op_e                out_alu_op,
        output logic [`CORE_REG_W-1:0] out_dst,
        output logic [`CORE_REG_W-1:0] out_src1,
        output logic [`CORE_REG_W-1:0] out_src2,
        output logic [`CORE_IMM_W-1:0] out_imm,
        output logic                   out_mask
);

        logic full;
        logic load;

        // pass-through when the taker drains us in the same cycle
        assign in_ready  = (!full || out_ready) && !flush;
        assign load      = in_valid && in_ready;
        assign out_valid = full;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        full <= 1'b0;
                else if (flush)
                        full <= 1'b0;   // younger than the retired jump
                else if (load)
                        full <= 1'b1;
                else if (out_ready)
                        full <= 1'b0;
        end

        // ---------------------------------------------------------------------------
        // control field register
        // ---------------------------------------------------------------------------
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_reg_wr_en   <= 1'b0;
                        out_vec_wr_en   <= 1'b0;
                        out_mem_read    <= 1'b0;
                        out_mem_write   <= 1'b0;
                        out_branch_jump <= 1'b0;
                        out_halt        <= 1'b0;
                        out_alu_op      <= ALU_ADD;
                        out_dst         <= '0;
                        out_src1        <= '0;
                        out_src2        <= '0;
                        out_imm         <= '0;
                        out_mask        <= 1'b0;
                end else if (load) begin
                        out_reg_wr_en   <= in_reg_wr_en;
                        out_vec_wr_en   <= in_vec_wr_en;
                        out_mem_read    <= in_mem_read;
                        out_mem_write   <= in_mem_write;
                        out_branch_jump <= in_branch_jump;
                        out_halt        <= in_halt;
                        out_alu_op      <= in_alu_op;
                        out_dst         <= in_dst;
                        out_src1        <= in_src1;
                        out_src2        <= in_src2;
                        out_imm         <= in_imm;
                        out_mask        <= in_mask;
                end
        end

endmodule

`default_nettype wire

/* design/retire_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module retire_unit
        import ctrl_pkg::*;
(
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   in_valid,
        output logic                   in_ready,
        input  logic                   in_reg_wr_en,
        input  logic                   in_vec_wr_en,
        input  logic                   in_mem_read,
        input  logic                   in_mem_write,
        input  logic                   in_branch_jump,
        input  logic                   in_halt,
        input  alu_op_e                in_alu_op,
        input  logic [`CORE_REG_W-1:0] in_dst,
        input  logic [`CORE_REG_W-1:0] in_src1,
        input  logic [`CORE_REG_W-1:0] in_src2,
        input  logic [`CORE_IMM_W-1:0] in_imm,
        input  logic                   in_mask,
        output logic                   ret_valid,
        output retire_kind_e           ret_kind,
        output alu_op_e                ret_alu_op,
        output logic [`CORE_REG_W-1:0] ret_dst,
        output logic [`CORE_REG_W-1:0] ret_src1,
        output logic [`CORE_REG_W-1:0] ret_src2,
        output logic [`CORE_IMM_W-1:0] ret_imm,
        output logic                   ret_mask,
        input  logic                   ret_ready,
        output logic                   flush,
        output logic                   halted
);

        retire_kind_e kind;
        logic         accept;

        always_comb begin
                if (in_halt)
                        kind = RET_HALT;
                else if (in_branch_jump)
                        kind = RET_JUMP;
                else if (in_mem_write)
                        kind = RET_STORE;
                else if (in_mem_read)
                        kind = RET_LOAD;        // load also writes a register
                else if (in_vec_wr_en)
                        kind = RET_VALU;
                else if (in_reg_wr_en)
                        kind = RET_ALU;
                else
                        kind = RET_NOP;
        end

        // the item seen during flush is younger than the jump
        assign in_ready = (!ret_valid || ret_ready) && !halted && !flush;
        assign accept   = in_valid && in_ready;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        ret_valid  <= 1'b0;
                        ret_kind   <= RET_NOP;
                        ret_alu_op <= ALU_ADD;
                        ret_dst    <= '0;
                        ret_src1   <= '0;
                        ret_src2   <= '0;
                        ret_imm    <= '0;
                        ret_mask   <= 1'b0;
                end else if (accept) begin
                        ret_valid  <= 1'b1;
                        ret_kind   <= kind;
                        ret_alu_op <= in_alu_op;
                        ret_dst    <= in_dst;
                        ret_src1   <= in_src1;
                        ret_src2   <= in_src2;
                        ret_imm    <= in_imm;
                        ret_mask   <= in_mask;
                end else if (ret_ready) begin
                        ret_valid  <= 1'b0;
                end
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        flush  <= 1'b0;
                        halted <= 1'b0;
                end else begin
                        flush  <= accept && in_branch_jump;     // single cycle pulse
                        halted <= halted || (accept && in_halt);
                end
        end

endmodule

`default_nettype wire

/* design/ctrl_pipe_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module ctrl_pipe_top
        import ctrl_pkg::*;
(
        input  logic                    clk,
        input  logic                    rst_n,
        input  logic                    insn_valid,
        output logic                    insn_ready,
        input  logic [`CORE_INSN_W-1:0] insn,
        output logic                    ret_valid,
        input  logic                    ret_ready,
        output retire_kind_e            ret_kind,
        output alu_op_e                 ret_alu_op,
        output logic [`CORE_REG_W-1:0]  ret_dst,
        output logic [`CORE_REG_W-1:0]  ret_src1,
        output logic [`CORE_REG_W-1:0]  ret_src2,
        output logic [`CORE_IMM_W-1:0]  ret_imm,
        output logic                    ret_mask,
        output logic                    flush,
        output logic                    halted
);

        localparam int N = `CORE_NUM_STAGES;

        // index 0 is the decoder side, index i+1 the output of stage i
        logic [N:0]             c_valid;
        logic [N:0]             c_ready;
        logic [N:0]             c_reg_wr_en;
        logic [N:0]             c_vec_wr_en;
        logic [N:0]             c_mem_read;
        logic [N:0]             c_mem_write;
        logic [N:0]             c_branch_jump;
        logic [N:0]             c_halt;
        logic [N:0]             c_mask;
        alu_op_e                c_alu_op [N+1];
        logic [`CORE_REG_W-1:0] c_dst    [N+1];
        logic [`CORE_REG_W-1:0] c_src1   [N+1];
        logic [`CORE_REG_W-1:0] c_src2   [N+1];
        logic [`CORE_IMM_W-1:0] c_imm    [N+1];

        assign c_valid[0] = insn_valid;
        assign insn_ready = c_ready[0];

        insn_decoder u_decoder (
                .insn               (insn),
                .ctrl_d_reg_wr_en   (c_reg_wr_en[0]),
                .ctrl_d_vec_wr_en   (c_vec_wr_en[0]),
                .ctrl_d_mem_read    (c_mem_read[0]),
                .ctrl_d_mem_write   (c_mem_write[0]),
                .ctrl_d_branch_jump (c_branch_jump[0]),
                .ctrl_d_halt        (c_halt[0]),
                .ctrl_d_alu_op      (c_alu_op[0]),
                .ctrl_d_dst         (c_dst[0]),
                .ctrl_d_src1        (c_src1[0]),
                .ctrl_d_src2        (c_src2[0]),
                .ctrl_d_imm         (c_imm[0]),
                .ctrl_d_mask        (c_mask[0])
        );

        // ---------------------------------------------------------------------------
        // control stage chain, flush fans out to every stage
        // ---------------------------------------------------------------------------
        for (genvar i = 0; i < N; i++) begin : g_stage
                control_stage u_stage (
                        .clk             (clk),
                        .rst_n           (rst_n),
                        .flush           (flush),
                        .in_valid        (c_valid[i]),
                        .in_ready        (c_ready[i]),
                        .in_reg_wr_en    (c_reg_wr_en[i]),
                        .in_vec_wr_en    (c_vec_wr_en[i]),
                        .in_mem_read     (c_mem_read[i]),
                        .in_mem_write    (c_mem_write[i]),
                        .in_branch_jump  (c_branch_jump[i]),
                        .in_halt         (c_halt[i]),
                        .in_alu_op       (c_alu_op[i]),
                        .in_dst          (c_dst[i]),
                        .in_src1         (c_src1[i]),
                        .in_src2         (c_src2[i]),
                        .in_imm          (c_imm[i]),
                        .in_mask         (c_mask[i]),
                        .out_valid       (c_valid[i+1]),
                        .out_ready       (c_ready[i+1]),
                        .out_reg_wr_en   (c_reg_wr_en[i+1]),
                        .out_vec_wr_en   (c_vec_wr_en[i+1]),
                        .out_mem_read    (c_mem_read[i+1]),
                        .out_mem_write   (c_mem_write[i+1]),
                        .out_branch_jump (c_branch_jump[i+1]),
                        .out_halt        (c_halt[i+1]),
                        .out_alu_op      (c_alu_op[i+1]),
                        .out_dst         (c_dst[i+1]),
                        .out_src1        (c_src1[i+1]),
                        .out_src2        (c_src2[i+1]),
                        .out_imm         (c_imm[i+1]),
                        .out_mask        (c_mask[i+1])
                );
        end

        retire_unit u_retire (
                .clk            (clk),
                .rst_n          (rst_n),
                .in_valid       (c_valid[N]),
                .in_ready       (c_ready[N]),
                .in_reg_wr_en   (c_reg_wr_en[N]),
                .in_vec_wr_en   (c_vec_wr_en[N]),
                .in_mem_read    (c_mem_read[N]),
                .in_mem_write   (c_mem_write[N]),
                .in_branch_jump (c_branch_jump[N]),
                .in_halt        (c_halt[N]),
                .in_alu_op      (c_alu_op[N]),
                .in_dst         (c_dst[N]),
                .in_src1        (c_src1[N]),
                .in_src2        (c_src2[N]),
                .in_imm         (c_imm[N]),
                .in_mask        (c_mask[N]),
                .ret_valid      (ret_valid),
                .ret_kind       (ret_kind),
                .ret_alu_op     (ret_alu_op),
                .ret_dst        (ret_dst),
                .ret_src1       (ret_src1),
                .ret_src2       (ret_src2),
                .ret_imm        (ret_imm),
                .ret_mask       (ret_mask),
                .ret_ready      (ret_ready),
                .flush          (flush),
                .halted         (halted)
        );

endmodule

`default_nettype wire

/* dv/ctrl_pipe_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module ctrl_pipe_checker (
        input wire logic        clk,
        input wire logic        rst_n,
        input wire logic        insn_ready,
        input wire logic        ret_valid,
        input wire logic        ret_ready,
        input wire logic [2:0]  ret_kind,
        input wire logic [3:0]  ret_alu_op,
        input wire logic [4:0]  ret_dst,
        input wire logic [4:0]  ret_src1,
        input wire logic [4:0]  ret_src2,
        input wire logic [12:0] ret_imm,
        input wire logic        ret_mask,
        input wire logic        flush,
        input wire logic        halted
);

        logic [35:0] payload;

        assign payload = {ret_kind, ret_alu_op, ret_dst, ret_src1, ret_src2, ret_imm, ret_mask};

        // record held under back-pressure
        a_ret_hold: assert property (@(posedge clk) disable iff (!rst_n)
                ret_valid && !ret_ready |=> ret_valid && $stable(payload))
                else $error("retire record changed while ret_ready was low");

        a_flush_pulse: assert property (@(posedge clk) disable iff (!rst_n)
                flush |=> !flush)
                else $error("flush lasted more than one cycle");

        // once the halted pipe has filled it stays full
        a_halt_block: assert property (@(posedge clk) disable iff (!rst_n)
                halted && !insn_ready |=> !insn_ready)
                else $error("insn_ready rose while halted");

        a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !ret_valid)
                else $error("ret_valid high during reset");

endmodule

bind ctrl_pipe_top ctrl_pipe_checker u_checker (.*);

`default_nettype wire

/* dv/ctrl_pipe_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_config.svh"

module ctrl_pipe_tb;

        localparam int N       = `CORE_NUM_STAGES;
        localparam int GMAX    = 32;
        localparam int TIMEOUT = 3000;

        logic        clk;
        logic        rst_n;
        logic        insn_valid;
        logic        insn_ready;
        logic [31:0] insn;
        logic        ret_valid;
        logic        ret_ready;
        logic [2:0]  ret_kind;
        logic [3:0]  ret_alu_op;
        logic [4:0]  ret_dst;
        logic [4:0]  ret_src1;
        logic [4:0]  ret_src2;
        logic [12:0] ret_imm;
        logic        ret_mask;
        logic        flush;
        logic        halted;

        logic [31:0] gold [0:GMAX*8-1];
        int          exp_q[$];
        bit          drop_q[$];
        int          errors;
        logic [31:0] rng;

        ctrl_pipe_top dut (.*);

        always #10 clk = ~clk;

        function automatic logic [31:0] xorshift(input logic [31:0] s);
                logic [31:0] x;
                x = s;
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
                if (got !== exp) begin
                        $display("Fail %s: got %h expected %h", name, got, exp);
                        errors++;
                end
        endtask

        task automatic check_record(input int e);
                check("ret_kind", 32'(ret_kind), gold[8*e+1]);
                check("ret_alu_op", 32'(ret_alu_op), gold[8*e+2]);
                check("ret_dst", 32'(ret_dst), gold[8*e+3]);
                check("ret_src1", 32'(ret_src1), gold[8*e+4]);
                check("ret_src2", 32'(ret_src2), gold[8*e+5]);
                check("ret_imm", 32'(ret_imm), gold[8*e+6]);
                check("ret_mask", 32'(ret_mask), gold[8*e+7]);
        endtask

        // forget everything accepted behind a retired jump
        task automatic drop_younger();
                int keep_e[$];
                bit keep_d[$];
                foreach (exp_q[i]) begin
                        if (!drop_q[i]) begin
                                keep_e.push_back(exp_q[i]);
                                keep_d.push_back(1'b0);
                        end
                end
                exp_q  = keep_e;
                drop_q = keep_d;
        endtask

        initial begin
                int n;
                int idx;
                int cyc;
                int e;
                int acc;
                int first_acc;
                int first_ret;
                int mark;
                int tests_failed;
                int flushes;
                int jumps;
                bit in_xfer;
                bit jump_pending;
                bit timed_out;

                clk        = 1'b0;
                rst_n      = 1'b0;
                insn_valid = 1'b0;
                insn       = '0;
                ret_ready  = 1'b0;
                rng        = 32'h50aa37aa;
                errors     = 0;
                tests_failed = 0;
                timed_out  = 1'b0;

                // kind column of the fill is never a legal kind
                for (int i = 0; i < GMAX*8; i++)
                        gold[i] = 32'hfff00000 | i;
                $readmemh("dv/ctrl_pipe_golden.txt", gold);
                n = 0;
                while (n < GMAX && gold[8*n+1] <= 6)
                        n++;
                if (n == 0) begin
                        $display("golden file holds no instructions");
                        errors++;
                end

                repeat (16) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;

                // ---------------------------------------------------------------------
                // golden stream with random back-pressure and jump flushes
                // ---------------------------------------------------------------------
                idx = 0;
                cyc = 0;
                first_acc = -1;
                first_ret = -1;
                flushes = 0;
                jumps = 0;
                in_xfer = 1'b0;
                jump_pending = 1'b0;
                mark = errors;
                while (!(idx == n && exp_q.size() == 0) && !timed_out) begin
                        @(negedge clk);
                        if (in_xfer)
                                idx++;
                        cyc++;
                        insn_valid = (idx < n);
                        insn       = (idx < n) ? gold[8*idx] : '0;
                        rng        = xorshift(rng);
                        ret_ready  = (first_ret < 0) ? 1'b1 : (rng[0] | rng[1]);   // 3 of 4
                        #1;
                        if (ret_valid && ret_ready) begin
                                if (first_ret < 0)
                                        first_ret = cyc;
                                if (exp_q.size() == 0) begin
                                        $display("a record retired while none was expected");
                                        errors++;
                                end else begin
                                        e = exp_q.pop_front();
                                        void'(drop_q.pop_front());
                                        check_record(e);
                                        if (gold[8*e+1] == 32'd4)
                                                jumps++;
                                end
                        end
                        if (flush) begin
                                flushes++;
                                drop_younger();
                                jump_pending = 1'b0;
                        end
                        in_xfer = insn_valid && insn_ready;
                        if (in_xfer) begin
                                if (first_acc < 0)
                                        first_acc = cyc;
                                exp_q.push_back(idx);
                                drop_q.push_back(jump_pending);
                                if (gold[8*idx+1] == 32'd4)
                                        jump_pending = 1'b1;
                        end
                        if (cyc > TIMEOUT)
                                timed_out = 1'b1;
                end
                // accept is sampled one cycle before its edge
                check("first_latency", 32'(first_ret - first_acc), 32'(N + 1));
                check("flush_pulses", 32'(flushes), 32'(jumps));       // one per retired jump
                if (errors != mark)
                        tests_failed++;
                $display("test stream: done, %0d mismatches", errors - mark);

                // ---------------------------------------------------------------------
                // halt blocks the pipe
                // ---------------------------------------------------------------------
                if (!timed_out) begin
                        mark = errors;
                        acc = 0;
                        check("halted", 32'(halted), 32'd1);
                        for (int c = 0; c < 40; c++) begin
                                @(negedge clk);
                                insn_valid = 1'b1;
                                insn       = 32'h00886005;
                                ret_ready  = 1'b1;
                                #1;
                                if (ret_valid) begin
                                        $display("a record retired after the halt");
                                        errors++;
                                end
                                if (insn_valid && insn_ready)
                                        acc++;
                        end
                        check("filler_accepts", 32'(acc), 32'(N));  // one per stage
                        check("insn_ready", 32'(insn_ready), 32'd0);
                        check("halted", 32'(halted), 32'd1);
                        if (errors != mark)
                                tests_failed++;
                        $display("test halt: done, %0d mismatches", errors - mark);
                end

                $display("tests 2, failed %0d, mismatches %0d", tests_failed, errors);
                if (timed_out) begin
                        $display("timeout waiting for the golden stream to retire");
                        $display("Verification failed");
                end else if (errors == 0) begin
                        $display("Verification passed");
                end else begin
                        $display("Verification failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

/* dv/ctrl_pipe_golden.txt */
// columns: insn kind alu_op dst src1 src2 imm mask
// kind 0 alu, 1 valu, 2 load, 3 store, 4 jump, 5 halt, 6 nop
00886005 0 0 01 02 03 0005 0
1214dabc 0 1 04 05 06 1abc 0
2f823fff 0 2 1f 00 11 1fff 0
33a12000 0 3 07 08 09 0000 0
452c0040 2 0 0a 0b 00 0040 0
5031a123 3 0 00 0c 0d 0123 0
80887000 1 8 01 02 03 0000 1
aa56cabc 1 a 14 15 16 0000 0
918c7000 1 9 03 03 03 0000 1
b07c2000 1 b 00 1f 01 0000 0
c10c80aa 6 0 02 03 04 00aa 0
f0000000 6 0 00 00 00 0000 0
60842010 4 0 01 01 01 0010 0
0298e001 0 0 05 06 07 0001 0
34a52002 0 3 09 09 09 0002 0
40886004 2 0 01 02 03 0004 0
831d1000 1 8 06 07 08 0000 1
5010a008 3 0 00 04 05 0008 0
70000000 5 0 00 00 00 0000 0

/* build.f */
+incdir+design
design/isa_pkg.sv
design/ctrl_pkg.sv
design/insn_decoder.sv
design/control_stage.sv
design/retire_unit.sv
design/ctrl_pipe_top.sv
dv/ctrl_pipe_checker.sv
dv/ctrl_pipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the control pipe testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
        -f build.f --top-module ctrl_pipe_tb -Mdir obj_dir -o sim_ctrl_pipe
if [ $? -ne 0 ]; then
        echo "build failed"
        exit 1
fi

./obj_dir/sim_ctrl_pipe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -qx "Verification passed" sim.log; then
        exit 0
fi
exit 1
